/* tb.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/core_decode.sv
rtl/core_execute.sv
rtl/core_writeback.sv
rtl/rv_core.sv
bench/core_checker.sv
bench/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - rtl

sources:
  - rtl/core_pkg.sv
  - rtl/core_decode.sv
  - rtl/core_execute.sv
  - rtl/core_writeback.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - bench/core_checker.sv
      - bench/tb_rv_core.sv

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps

`include "core_macros.svh"

module tb_rv_core import core_pkg::*; ();

    localparam logic [15:0] SEED        = 16'd17442;
    localparam int          DRAIN_LIMIT = 20;
    localparam int          N_RANDOM    = 40;
    // opcodes the core does not implement
    localparam logic [6:0]  OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0]  OPC_LOAD    = 7'b0000011;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    inst_t       inst;
    logic        commit_valid;
    inst_t       commit_inst;
    reg_idx_t    commit_rd;
    logic        commit_we;
    xlen_t       commit_data;
    logic        commit_illegal;
    logic [15:0] lfsr;
    reg_idx_t    rd_sel;
    reg_idx_t    rs1_sel;
    reg_idx_t    rs2_sel;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;

    rv_core u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .inst_valid_i     (inst_valid),
        .inst_i           (inst),
        .commit_valid_o   (commit_valid),
        .commit_inst_o    (commit_inst),
        .commit_rd_o      (commit_rd),
        .commit_we_o      (commit_we),
        .commit_data_o    (commit_data),
        .commit_illegal_o (commit_illegal)
    );

    core_checker u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .inst_valid_i     (inst_valid),
        .inst_i           (inst),
        .commit_valid_i   (commit_valid),
        .commit_inst_i    (commit_inst),
        .commit_rd_i      (commit_rd),
        .commit_we_i      (commit_we),
        .commit_data_i    (commit_data),
        .commit_illegal_i (commit_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // i-type layout, r-type passes {funct7, rs2} as the upper field
    function automatic inst_t encode(logic [11:0] hi, reg_idx_t rs1, logic [2:0] fn3,
                                     reg_idx_t rd, logic [6:0] opc);
        return {hi, rs1, fn3, rd, opc};
    endfunction

    task automatic pick_regs();
        rd_sel  = reg_idx_t'(rand_bits(5));
        rs1_sel = reg_idx_t'(rand_bits(5));
        rs2_sel = reg_idx_t'(rand_bits(5));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic issue(inst_t word, int gap);
        inst_valid = 1'b1;
        inst       = word;
        next_cycle();
        inst_valid = 1'b0;
        repeat (gap)
            next_cycle();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (u_checker.pending() != 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (u_checker.pending() != 0) begin
            $display("timeout: %0d instructions never retired", u_checker.pending());
            $display("Finished with errors");
            $finish;
        end
        repeat (3)
            next_cycle();
    endtask

    // ************************************************************
    // test program
    // ************************************************************
    initial begin
        lfsr       = SEED;
        rst_n      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        repeat (8)
            @(posedge clk);
        #10;
        rst_n = 1'b0;

        // nothing retires out of reset, unwritten registers read zero
        u_checker.start_test("reset");
        repeat (4)
            next_cycle();
        issue(encode({7'h00, 5'd2}, 5'd1, 3'd0, 5'd3, `CORE_OPC_OP), 1);
        issue(encode({7'h00, 5'd31}, 5'd30, 3'd0, 5'd4, `CORE_OPC_OP), 0);
        drain();
        u_checker.end_test();

        // every register through lui first
        u_checker.start_test("lui_op_imm");
        for (int r = 1; r < 32; r++)
            issue({20'(rand_bits(20)), reg_idx_t'(r), `CORE_OPC_LUI}, 0);
        for (int n = 0; n < N_RANDOM; n++) begin
            pick_regs();
            f3  = 3'(rand_bits(3));
            imm = 12'(rand_bits(12));
            // shifts keep a 6-bit shamt, bit 10 picks srai
            if (f3 == `CORE_F3_SLL)
                imm[11:6] = 6'b0;
            else if (f3 == `CORE_F3_SR)
                imm[11:6] = {1'b0, imm[10], 4'b0};
            issue(encode(imm, rs1_sel, f3, rd_sel, `CORE_OPC_OP_IMM), int'(rand_bits(1)));
        end
        drain();
        u_checker.end_test();

        u_checker.start_test("op_reg_reg");
        for (int n = 0; n < N_RANDOM; n++) begin
            pick_regs();
            f3 = 3'(rand_bits(3));
            f7 = 7'h00;
            if ((f3 == `CORE_F3_ADD || f3 == `CORE_F3_SR) && rand_bits(1) == 1)
                f7 = 7'h20;
            issue(encode({f7, rs2_sel}, rs1_sel, f3, rd_sel, `CORE_OPC_OP), int'(rand_bits(1)));
        end
        drain();
        u_checker.end_test();

        // rs1 from d instructions back, rs2 from the one before
        // first pass back to back, second pass spaced out
        u_checker.start_test("forwarding");
        for (int s = 0; s < 2; s++) begin
            for (int d = 1; d <= 3; d++) begin
                for (int n = 0; n < 12; n++) begin
                    rd_sel  = reg_idx_t'(8 + n % d);
                    rs2_sel = reg_idx_t'(8 + (n + d - 1) % d);
                    f7      = n[0] ? 7'h20 : 7'h00;
                    imm     = 12'(rand_bits(12));
                    if (n % 4 == 3)
                        issue(encode(imm, rd_sel, 3'd0, rd_sel, `CORE_OPC_OP_IMM), 3 * s);
                    else
                        issue(encode({f7, rs2_sel}, rd_sel, 3'd0, rd_sel, `CORE_OPC_OP), 3 * s);
                end
            end
        end
        drain();
        u_checker.end_test();

        u_checker.start_test("x0_illegal");
        issue(encode(12'h123, 5'd9, 3'd0, 5'd0, `CORE_OPC_OP_IMM), 0);
        issue(encode({7'h00, 5'd9}, 5'd8, `CORE_F3_OR, 5'd0, `CORE_OPC_OP), 0);
        issue(encode({7'h00, 5'd0}, 5'd0, 3'd0, 5'd12, `CORE_OPC_OP), 0);
        for (int n = 0; n < 8; n++) begin
            pick_regs();
            imm = 12'(rand_bits(12));
            f3  = 3'(rand_bits(3));
            issue(encode(imm, rs1_sel, f3, rd_sel, n[0] ? OPC_BRANCH : OPC_LOAD), 0);
            // read back the register the illegal one named
            issue(encode({7'h00, 5'd0}, rd_sel, 3'd0, 5'd13, `CORE_OPC_OP), 0);
        end
        // mul encoding, not implemented
        issue(encode({7'h01, 5'd9}, 5'd9, 3'd0, 5'd9, `CORE_OPC_OP), 0);
        issue(encode({7'h00, 5'd0}, 5'd9, 3'd0, 5'd14, `CORE_OPC_OP), 0);
        drain();
        u_checker.end_test();

        // start from a value that crosses bit 31
        u_checker.start_test("word_ops");
        issue({20'h80000, 5'd14, `CORE_OPC_LUI}, 0);
        issue(encode(12'hfff, 5'd14, 3'd0, 5'd15, `CORE_OPC_OP_IMM32), 0);
        issue(encode({7'h20, 5'd14}, 5'd15, 3'd0, 5'd16, `CORE_OPC_OP32), 0);
        for (int n = 0; n < N_RANDOM; n++) begin
            pick_regs();
            imm = 12'(rand_bits(12));
            if (imm[0])
                issue(encode(imm, rs1_sel, 3'd0, rd_sel, `CORE_OPC_OP_IMM32), 0);
            else
                issue(encode({imm[11] ? 7'h20 : 7'h00, rs2_sel}, rs1_sel, 3'd0, rd_sel,
                             `CORE_OPC_OP32), 0);
        end
        drain();
        u_checker.end_test();

        $display("tests passed %0d, failed %0d, errors %0d", u_checker.tests_passed,
                 u_checker.tests_failed, u_checker.total_errors);
        if (u_checker.total_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* bench/core_checker.sv */
`timescale 1ns/1ps

`include "core_macros.svh"

module core_checker import core_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     inst_valid_i,
    input inst_t    inst_i,
    input logic     commit_valid_i,
    input inst_t    commit_inst_i,
    input reg_idx_t commit_rd_i,
    input logic     commit_we_i,
    input xlen_t    commit_data_i,
    input logic     commit_illegal_i
);

    // falling edges from strobe sample to commit sample
    localparam int COMMIT_GAP = 2;

    typedef struct packed {
        int       cycle;
        inst_t    inst;
        reg_idx_t rd;
        logic     we;
        logic     illegal;
        xlen_t    data;
    } commit_t;

    commit_t exp_q[$];
    commit_t cur;
    xlen_t   model [0:`CORE_NREG-1];
    int      cycle = 0;
    int      test_errors = 0;
    int      total_errors = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    string   test_name = "reset";

    // ************************************************************
    // reference model
    // ************************************************************

    // expected commit from the ISA rules and the model registers
    function automatic commit_t ref_execute(inst_t inst);
        commit_t    e;
        xlen_t      a;
        xlen_t      b;
        xlen_t      r;
        logic [5:0] sh;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ill;
        f3  = inst[14:12];
        f7  = inst[31:25];
        a   = model[inst[19:15]];
        // opcode bit 5 marks the register-register forms
        b   = inst[5] ? model[inst[24:20]] : {{52{inst[31]}}, inst[31:20]};
        sh  = b[5:0];
        r   = '0;
        ill = 1'b0;
        case (inst[6:0])
            `CORE_OPC_LUI:
                r = {{32{inst[31]}}, inst[31:12], 12'b0};
            `CORE_OPC_OP_IMM, `CORE_OPC_OP: begin
                if (inst[5])
                    ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                else if (f3 == 3'd1)
                    ill = (f7[6:1] != 6'h00);
                else if (f3 == 3'd5)
                    ill = (f7[6:1] != 6'h00 && f7[6:1] != 6'h10);
                case (f3)
                    3'd0: r = (inst[5] && inst[30]) ? a - b : a + b;
                    3'd1: r = a << sh;
                    3'd2: r = {63'b0, $signed(a) < $signed(b)};
                    3'd3: r = {63'b0, a < b};
                    3'd4: r = a ^ b;
                    3'd5: begin
                        if (inst[30])
                            r = $signed(a) >>> sh;
                        else
                            r = a >> sh;
                    end
                    3'd6: r = a | b;
                    default: r = a & b;
                endcase
            end
            // addiw, addw, subw
            `CORE_OPC_OP_IMM32, `CORE_OPC_OP32: begin
                ill = (f3 != 3'd0) || (inst[5] && f7 != 7'h00 && f7 != 7'h20);
                r   = (inst[5] && inst[30]) ? a - b : a + b;
                r   = {{32{r[31]}}, r[31:0]};
            end
            default:
                ill = 1'b1;
        endcase
        e.cycle   = cycle;
        e.inst    = inst;
        e.rd      = inst[11:7];
        e.illegal = ill;
        e.we      = !ill && (e.rd != 0);
        e.data    = ill ? '0 : r;
        return e;
    endfunction

    // ************************************************************
    // reporting
    // ************************************************************
    task automatic report_error(string what);
        $display("ERROR %s: %s", test_name, what);
        test_errors++;
        total_errors++;
    endtask

    task automatic check_field(string field, xlen_t exp_v, xlen_t act_v);
        if (exp_v !== act_v) begin
            $display("MISMATCH %s %s: expected %h actual %h", test_name, field, exp_v, act_v);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic compare_commit();
        if (exp_q.size() == 0) begin
            report_error("commit arrived with no instruction outstanding");
        end else begin
            cur = exp_q.pop_front();
            if (cycle - cur.cycle != COMMIT_GAP)
                report_error($sformatf("instruction %h retired %0d cycles after its strobe",
                                       cur.inst, cycle - cur.cycle));
            check_field("inst", cur.inst, commit_inst_i);
            check_field("rd", cur.rd, commit_rd_i);
            check_field("we", cur.we, commit_we_i);
            check_field("illegal", cur.illegal, commit_illegal_i);
            if (!cur.illegal)
                check_field("data", cur.data, commit_data_i);
        end
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    // inputs move 10 ns after the rising edge, settled by the falling one
    always @(negedge clk) begin
        cycle++;
        if (rst_n) begin
            for (int i = 0; i < `CORE_NREG; i++)
                model[i] = '0;
            exp_q.delete();
            if (commit_valid_i)
                report_error("commit during reset");
        end else begin
            if (commit_valid_i)
                compare_commit();
            if (inst_valid_i) begin
                cur = ref_execute(inst_i);
                if (cur.we)
                    model[cur.rd] = cur.data;
                exp_q.push_back(cur);
            end
        end
    end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     inst_valid_i,
    input  inst_t    inst_i,
    output logic     commit_valid_o,
    output inst_t    commit_inst_o,
    output reg_idx_t commit_rd_o,
    output logic     commit_we_o,
    output xlen_t    commit_data_o,
    output logic     commit_illegal_o
);

    // register file read
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    // ID/EX
    logic     ex_valid;
    inst_t    ex_inst;
    alu_op_t  ex_alu_op;
    logic     ex_word;
    xlen_t    ex_op1;
    xlen_t    ex_op2;
    reg_idx_t ex_rd;
    logic     ex_we;
    logic     ex_illegal;

    // forwarding from execute
    logic     fwd_we;
    reg_idx_t fwd_rd;
    xlen_t    fwd_data;

    // EX/WB
    logic     wb_valid;
    inst_t    wb_inst;
    reg_idx_t wb_rd;
    logic     wb_we;
    xlen_t    wb_data;
    logic     wb_illegal;

    core_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_we_i     (fwd_we),
        .fwd_rd_i     (fwd_rd),
        .fwd_data_i   (fwd_data),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .ex_valid_o   (ex_valid),
        .ex_inst_o    (ex_inst),
        .ex_alu_op_o  (ex_alu_op),
        .ex_word_o    (ex_word),
        .ex_op1_o     (ex_op1),
        .ex_op2_o     (ex_op2),
        .ex_rd_o      (ex_rd),
        .ex_we_o      (ex_we),
        .ex_illegal_o (ex_illegal)
    );

    core_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid_i   (ex_valid),
        .ex_inst_i    (ex_inst),
        .ex_alu_op_i  (ex_alu_op),
        .ex_word_i    (ex_word),
        .ex_op1_i     (ex_op1),
        .ex_op2_i     (ex_op2),
        .ex_rd_i      (ex_rd),
        .ex_we_i      (ex_we),
        .ex_illegal_i (ex_illegal),
        .fwd_we_o     (fwd_we),
        .fwd_rd_o     (fwd_rd),
        .fwd_data_o   (fwd_data),
        .wb_valid_o   (wb_valid),
        .wb_inst_o    (wb_inst),
        .wb_rd_o      (wb_rd),
        .wb_we_o      (wb_we),
        .wb_data_o    (wb_data),
        .wb_illegal_o (wb_illegal)
    );

    core_writeback u_writeback (
        .clk              (clk),
        .rst_n            (rst_n),
        .wb_valid_i       (wb_valid),
        .wb_inst_i        (wb_inst),
        .wb_rd_i          (wb_rd),
        .wb_we_i          (wb_we),
        .wb_data_i        (wb_data),
        .wb_illegal_i     (wb_illegal),
        .rs1_idx_i        (rs1_idx),
        .rs2_idx_i        (rs2_idx),
        .rs1_data_o       (rs1_data),
        .rs2_data_o       (rs2_data),
        .commit_valid_o   (commit_valid_o),
        .commit_inst_o    (commit_inst_o),
        .commit_rd_o      (commit_rd_o),
        .commit_we_o      (commit_we_o),
        .commit_data_o    (commit_data_o),
        .commit_illegal_o (commit_illegal_o)
    );

endmodule

/* rtl/core_writeback.sv */
`timescale 1ns/1ps

module core_writeback import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_valid_i,
    input  inst_t    wb_inst_i,
    input  reg_idx_t wb_rd_i,
    input  logic     wb_we_i,
    input  xlen_t    wb_data_i,
    input  logic     wb_illegal_i,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o,
    output logic     commit_valid_o,
    output inst_t    commit_inst_o,
    output reg_idx_t commit_rd_o,
    output logic     commit_we_o,
    output xlen_t    commit_data_o,
    output logic     commit_illegal_o
);

    // x1..x31, x0 has no storage
    xlen_t regs [1:31];
    logic  wr_en;

    assign wr_en = wb_valid_i && wb_we_i && (wb_rd_i != '0);

    // write-first read port
    function automatic xlen_t read_port(reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wr_en && wb_rd_i == idx)
            return wb_data_i;
        else
            return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    assign rs1_data_o = read_port(rs1_idx_i);
    assign rs2_data_o = read_port(rs2_idx_i);

    // commit report straight from EX/WB
    assign commit_valid_o   = wb_valid_i;
    assign commit_inst_o    = wb_inst_i;
    assign commit_rd_o      = wb_rd_i;
    assign commit_we_o      = wb_we_i;
    assign commit_data_o    = wb_data_i;
    assign commit_illegal_o = wb_illegal_i;

endmodule

/* rtl/core_execute.sv */
`timescale 1ns/1ps

`include "core_macros.svh"

module core_execute import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ex_valid_i,
    input  inst_t    ex_inst_i,
    input  alu_op_t  ex_alu_op_i,
    input  logic     ex_word_i,
    input  xlen_t    ex_op1_i,
    input  xlen_t    ex_op2_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_we_i,
    input  logic     ex_illegal_i,
    output logic     fwd_we_o,
    output reg_idx_t fwd_rd_o,
    output xlen_t    fwd_data_o,
    output logic     wb_valid_o,
    output inst_t    wb_inst_o,
    output reg_idx_t wb_rd_o,
    output logic     wb_we_o,
    output xlen_t    wb_data_o,
    output logic     wb_illegal_o
);

    logic [5:0] shamt;
    xlen_t      alu_res;
    xlen_t      result;

    // shift amount from the low six bits of operand 2
    assign shamt = ex_op2_i[5:0];

    // ************************************************************
    // 64-bit alu
    // ************************************************************
    always_comb begin
        case (ex_alu_op_i)
            `CORE_ALU_ADD:  alu_res = ex_op1_i + ex_op2_i;
            `CORE_ALU_SUB:  alu_res = ex_op1_i - ex_op2_i;
            `CORE_ALU_SLL:  alu_res = ex_op1_i << shamt;
            `CORE_ALU_SLT:  alu_res = xlen_t'($signed(ex_op1_i) < $signed(ex_op2_i));
            `CORE_ALU_SLTU: alu_res = xlen_t'(ex_op1_i < ex_op2_i);
            `CORE_ALU_XOR:  alu_res = ex_op1_i ^ ex_op2_i;
            `CORE_ALU_SRL:  alu_res = ex_op1_i >> shamt;
            `CORE_ALU_SRA:  alu_res = $signed(ex_op1_i) >>> shamt;
            `CORE_ALU_OR:   alu_res = ex_op1_i | ex_op2_i;
            `CORE_ALU_AND:  alu_res = ex_op1_i & ex_op2_i;
            `CORE_ALU_PASS: alu_res = ex_op2_i;
            default:        alu_res = '0;
        endcase
    end

    // w forms keep the low word, sign-extended
    assign result = ex_word_i ? {{(`CORE_XLEN-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

    // live result back to decode
    assign fwd_we_o   = ex_valid_i && ex_we_i;
    assign fwd_rd_o   = ex_rd_i;
    assign fwd_data_o = result;

    // ************************************************************
    // EX/WB register
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            wb_valid_o   <= 1'b0;
            wb_we_o      <= 1'b0;
            wb_illegal_o <= 1'b0;
        end else begin
            wb_valid_o   <= ex_valid_i;
            wb_we_o      <= ex_valid_i && ex_we_i;
            wb_illegal_o <= ex_valid_i && ex_illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            wb_inst_o <= ex_inst_i;
            wb_rd_o   <= ex_rd_i;
            wb_data_o <= result;
        end
    end

endmodule

/* rtl/core_decode.sv */
`timescale 1ns/1ps

`include "core_macros.svh"

module core_decode import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     inst_valid_i,
    input  inst_t    inst_i,
    input  xlen_t    rs1_data_i,
    input  xlen_t    rs2_data_i,
    input  logic     fwd_we_i,
    input  reg_idx_t fwd_rd_i,
    input  xlen_t    fwd_data_i,
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    output logic     ex_valid_o,
    output inst_t    ex_inst_o,
    output alu_op_t  ex_alu_op_o,
    output logic     ex_word_o,
    output xlen_t    ex_op1_o,
    output xlen_t    ex_op2_o,
    output reg_idx_t ex_rd_o,
    output logic     ex_we_o,
    output logic     ex_illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_sh;
    xlen_t      imm;
    logic       use_imm;
    logic       word;
    logic       legal;
    alu_op_t    alu_op;
    xlen_t      rs1_val;
    xlen_t      rs2_val;

    // base operation selected by funct3 alone
    function automatic alu_op_t f3_alu_op(logic [2:0] f3);
        case (f3)
            `CORE_F3_ADD:  return `CORE_ALU_ADD;
            `CORE_F3_SLL:  return `CORE_ALU_SLL;
            `CORE_F3_SLT:  return `CORE_ALU_SLT;
            `CORE_F3_SLTU: return `CORE_ALU_SLTU;
            `CORE_F3_XOR:  return `CORE_ALU_XOR;
            `CORE_F3_SR:   return `CORE_ALU_SRL;
            `CORE_F3_OR:   return `CORE_ALU_OR;
            default:       return `CORE_ALU_AND;
        endcase
    endfunction

    assign opcode    = inst_i[6:0];
    assign funct3    = inst_i[14:12];
    assign funct7    = inst_i[31:25];
    assign rd        = inst_i[11:7];
    assign rs1_idx_o = inst_i[19:15];
    assign rs2_idx_o = inst_i[24:20];

    // immediates
    assign imm_i  = {{(`CORE_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {{(`CORE_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_sh = {{(`CORE_XLEN-6){1'b0}}, inst_i[25:20]};

    // ************************************************************
    // opcode and funct decode
    // ************************************************************
    always_comb begin
        alu_op  = `CORE_ALU_PASS;
        use_imm = 1'b1;
        imm     = imm_i;
        word    = 1'b0;
        legal   = 1'b1;
        case (opcode)
            `CORE_OPC_LUI: begin
                imm = imm_u;
            end
            `CORE_OPC_OP_IMM: begin
                alu_op = f3_alu_op(funct3);
                if (funct3 == `CORE_F3_SLL) begin
                    imm   = imm_sh;
                    legal = (funct7[6:1] == 6'b000000);
                end else if (funct3 == `CORE_F3_SR) begin
                    imm   = imm_sh;
                    legal = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
                    if (inst_i[30])
                        alu_op = `CORE_ALU_SRA;
                end
            end
            `CORE_OPC_OP: begin
                use_imm = 1'b0;
                alu_op  = f3_alu_op(funct3);
                if (funct7 == 7'b0100000 && funct3 == `CORE_F3_ADD)
                    alu_op = `CORE_ALU_SUB;
                else if (funct7 == 7'b0100000 && funct3 == `CORE_F3_SR)
                    alu_op = `CORE_ALU_SRA;
                else
                    legal = (funct7 == 7'b0000000);
            end
            // addiw only
            `CORE_OPC_OP_IMM32: begin
                word   = 1'b1;
                alu_op = `CORE_ALU_ADD;
                legal  = (funct3 == `CORE_F3_ADD);
            end
            // addw and subw only
            `CORE_OPC_OP32: begin
                use_imm = 1'b0;
                word    = 1'b1;
                alu_op  = inst_i[30] ? `CORE_ALU_SUB : `CORE_ALU_ADD;
                legal   = (funct3 == `CORE_F3_ADD) &&
                          ((funct7 == 7'b0000000) || (funct7 == 7'b0100000));
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        // illegal encodings pass a zero through the alu
        if (!legal) begin
            alu_op  = `CORE_ALU_PASS;
            use_imm = 1'b1;
            imm     = '0;
            word    = 1'b0;
        end
    end

    // result still in execute wins over the register file
    assign rs1_val = (fwd_we_i && fwd_rd_i == rs1_idx_o) ? fwd_data_i : rs1_data_i;
    assign rs2_val = (fwd_we_i && fwd_rd_i == rs2_idx_o) ? fwd_data_i : rs2_data_i;

    // ************************************************************
    // ID/EX register
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            ex_valid_o   <= 1'b0;
            ex_we_o      <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else begin
            ex_valid_o   <= inst_valid_i;
            ex_we_o      <= inst_valid_i && legal && (rd != '0);
            ex_illegal_o <= inst_valid_i && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            ex_inst_o   <= inst_i;
            ex_alu_op_o <= alu_op;
            ex_word_o   <= word;
            ex_op1_o    <= rs1_val;
            ex_op2_o    <= use_imm ? imm : rs2_val;
            ex_rd_o     <= rd;
        end
    end

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    // ************************************************************
    // vector types shared by the pipeline stages
    // ************************************************************

    // one integer register, also one alu operand or result
    typedef logic [63:0] xlen_t;

    // raw 32-bit instruction word
    typedef logic [31:0] inst_t;

    // index into the 32-entry register file
    typedef logic [4:0] reg_idx_t;

    // alu operation, values from the CORE_ALU_* macros
    typedef logic [3:0] alu_op_t;

endpackage

/* rtl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// architectural sizes
`define CORE_XLEN 64
`define CORE_NREG 32

// major opcodes, inst[6:0]
`define CORE_OPC_LUI      7'b0110111
`define CORE_OPC_OP_IMM   7'b0010011
`define CORE_OPC_OP       7'b0110011
`define CORE_OPC_OP_IMM32 7'b0011011
`define CORE_OPC_OP32     7'b0111011

// funct3 of the OP and OP-IMM groups
`define CORE_F3_ADD  3'b000
`define CORE_F3_SLL  3'b001
`define CORE_F3_SLT  3'b010
`define CORE_F3_SLTU 3'b011
`define CORE_F3_XOR  3'b100
`define CORE_F3_SR   3'b101
`define CORE_F3_OR   3'b110
`define CORE_F3_AND  3'b111

// alu operation codes
`define CORE_ALU_ADD  4'd0
`define CORE_ALU_SUB  4'd1
`define CORE_ALU_SLL  4'd2
`define CORE_ALU_SLT  4'd3
`define CORE_ALU_SLTU 4'd4
`define CORE_ALU_XOR  4'd5
`define CORE_ALU_SRL  4'd6
`define CORE_ALU_SRA  4'd7
`define CORE_ALU_OR   4'd8
`define CORE_ALU_AND  4'd9
// pass operand 2 through, used by lui
`define CORE_ALU_PASS 4'd10

`endif
